/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache directory testbench, pass or fail taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_cache_dir -o tb_cache_dir > build.log 2>&1 \
   && ./obj_dir/tb_cache_dir > sim.log 2>&1 \
   || { echo "build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log \
   && { echo "simulation failed"; exit 1; } \
   || { echo "simulation passed"; exit 0; }

/* sim/tb_cache_dir.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache_dir;

   localparam int n_tests  = 14;
   localparam int clk_half = 4;                            // 8 ns period
   localparam int max_wait = 16;                           // edges allowed for ack to rise
   localparam int wdog_ns  = (n_tests * 40 + 4) * 2 * clk_half;
   localparam cache_ctrl_pkg::dir_op_e op_lk  = cache_ctrl_pkg::op_lookup;
   localparam cache_ctrl_pkg::dir_op_e op_inv = cache_ctrl_pkg::op_invalidate;

   // request and its hand-computed response
   typedef struct packed {
      cache_fmt_pkg::dir_req_t  req;
      cache_fmt_pkg::dir_resp_t exp;
   } test_vec_t;

   logic                     clk;
   logic                     rst_n;
   logic                     req;
   cache_fmt_pkg::dir_req_t  req_in;
   logic                     ack;
   cache_fmt_pkg::dir_resp_t resp;

   test_vec_t   tbl [n_tests];
   logic [31:0] lfsr;
   int          err_cnt;
   int          pass_cnt;

   cache_dir_top u_cache_dir_top (
      .clk    (clk),
      .rst_n  (rst_n),
      .req    (req),
      .req_in (req_in),
      .ack    (ack),
      .resp   (resp)
   );

   always #(clk_half) clk = ~clk;

   function automatic test_vec_t build_entry(
      input cache_ctrl_pkg::dir_op_e          op,
      input logic [`CACHE_TAG_W-1:0]    tag,
      input logic [`CACHE_NLINES_W-1:0] set,
      input logic                       hit,
      input logic [`CACHE_NWAY_W-1:0]   way,
      input logic                       ev,
      input logic [`CACHE_TAG_W-1:0]    ev_tag
   );
      test_vec_t v;
      v.req.op          = op;
      v.req.addr        = {tag, set};   // tag over set index
      v.exp.hit         = hit;
      v.exp.way         = way;
      v.exp.evict_valid = ev;
      v.exp.evict_tag   = ev_tag;
      return v;
   endfunction

   // tree bits given as (root, node 2, node 3) after each access
   task automatic load_table();
      tbl[0]  = build_entry(op_lk,  12'h0a1, 4'd3, 1'b0, 2'd0, 1'b0, 12'h000); // (1,1,0)
      tbl[1]  = build_entry(op_lk,  12'h0b2, 4'd3, 1'b0, 2'd1, 1'b0, 12'h000); // (1,0,0)
      tbl[2]  = build_entry(op_lk,  12'h0c3, 4'd3, 1'b0, 2'd2, 1'b0, 12'h000); // (0,0,1)
      tbl[3]  = build_entry(op_lk,  12'h0d4, 4'd3, 1'b0, 2'd3, 1'b0, 12'h000); // (0,0,0)
      tbl[4]  = build_entry(op_lk,  12'h0a1, 4'd3, 1'b1, 2'd0, 1'b0, 12'h000); // (1,1,0)
      // set full so root right then node 3 left gives way 2
      tbl[5]  = build_entry(op_lk,  12'h0e5, 4'd3, 1'b0, 2'd2, 1'b1, 12'h0c3); // (0,1,1)
      // root left then node 2 right gives way 1
      tbl[6]  = build_entry(op_lk,  12'h0f6, 4'd3, 1'b0, 2'd1, 1'b1, 12'h0b2); // (1,0,1)
      tbl[7]  = build_entry(op_lk,  12'h0d4, 4'd3, 1'b1, 2'd3, 1'b0, 12'h000);
      tbl[8]  = build_entry(op_lk,  12'h0e5, 4'd3, 1'b1, 2'd2, 1'b0, 12'h000);
      tbl[9]  = build_entry(op_inv, 12'h0a1, 4'd3, 1'b1, 2'd0, 1'b0, 12'h000); // tree kept
      tbl[10] = build_entry(op_lk,  12'h0a1, 4'd3, 1'b0, 2'd0, 1'b0, 12'h000); // freed way
      tbl[11] = build_entry(op_inv, 12'h0b2, 4'd3, 1'b0, 2'd0, 1'b0, 12'h000); // absent
      tbl[12] = build_entry(op_lk,  12'h0a1, 4'd5, 1'b0, 2'd0, 1'b0, 12'h000); // set 5 cold
      tbl[13] = build_entry(op_lk,  12'h0f6, 4'd3, 1'b1, 2'd1, 1'b0, 12'h000);
   endtask

   // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);                           // one step per bit
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic check_resp(input cache_fmt_pkg::dir_resp_t got,
                             input cache_fmt_pkg::dir_resp_t exp);
      if (got.hit !== exp.hit) begin
         $display("Error at %0d ns: resp.hit got %0b expected %0b", $time, got.hit, exp.hit);
         err_cnt++;
      end
      if (got.way !== exp.way) begin
         $display("Error at %0d ns: resp.way got %0d expected %0d", $time, got.way, exp.way);
         err_cnt++;
      end
      if (got.evict_valid !== exp.evict_valid) begin
         $display("Error at %0d ns: resp.evict_valid got %0b expected %0b",
                  $time, got.evict_valid, exp.evict_valid);
         err_cnt++;
      end
      if (got.evict_tag !== exp.evict_tag) begin
         $display("Error at %0d ns: resp.evict_tag got %03h expected %03h",
                  $time, got.evict_tag, exp.evict_tag);
         err_cnt++;
      end
   endtask

   task automatic check_ack_timing(input int got, input int exp);
      if (got != exp) begin
         $display("Error at %0d ns: ack latency got %0d edges expected %0d", $time, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0d ns: %s got %0b expected %0b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // one full four-phase handshake for a table row
   task automatic run_entry(input int idx);
      int edges;
      int idle;
      int err_before;
      err_before = err_cnt;
      edges      = 0;
      @(posedge clk);
      req    <= 1'b1;
      req_in <= tbl[idx].req;
      @(negedge clk);
      while (!ack && edges < max_wait) begin
         @(posedge clk);
         edges++;                                          // edges after req went high
         @(negedge clk);
      end
      if (!ack) begin
         $display("entry %0d: ack never rose while req was held high", idx);
         err_cnt++;
      end
      check_ack_timing(edges, 2);
      check_resp(resp, tbl[idx].exp);
      rand_bits(3, idle);                                  // 0 to 7 extra cycles with req high
      repeat (idle) begin
         @(negedge clk);
         check_level("ack", ack, 1'b1);
         check_resp(resp, tbl[idx].exp);                   // response must hold
      end
      @(posedge clk);
      req <= 1'b0;
      @(negedge clk);
      check_level("ack", ack, 1'b1);                       // req low not sampled yet
      @(negedge clk);
      check_level("ack", ack, 1'b0);                       // falls one edge later
      if (err_cnt == err_before) begin
         pass_cnt++;
         $display("entry %0d addr %04h op %0d: ok", idx, tbl[idx].req.addr, tbl[idx].req.op);
      end else begin
         $display("entry %0d addr %04h op %0d: failed", idx, tbl[idx].req.addr,
                  tbl[idx].req.op);
      end
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      req      = 1'b0;
      req_in   = '0;
      lfsr     = 32'hc8ba;
      err_cnt  = 0;
      pass_cnt = 0;
      load_table();
      repeat (4) @(posedge clk);                           // 4 cycles in reset
      rst_n <= 1'b1;
      @(negedge clk);
      check_level("ack", ack, 1'b0);                       // idle after reset
      for (int i = 0; i < n_tests; i++)
         run_entry(i);
      $display("entries %0d, passed %0d, failed %0d, errors %0d",
               n_tests, pass_cnt, n_tests - pass_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // hang guard of 40 cycles per table row
   initial begin
      #(wdog_ns);
      $display("watchdog: run did not finish within %0d ns, the handshake stalled", wdog_ns);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* sources.f */
+incdir+src
src/cache_ctrl_pkg.sv
src/cache_fmt_pkg.sv
src/tag_store.sv
src/replacement_policy.sv
src/dir_controller.sv
src/cache_dir_top.sv
sim/tb_cache_dir.sv

/* src/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

   // request opcodes seen on the external port
   typedef enum logic {
      op_lookup     = 1'b0,   // find, allocate on miss
      op_invalidate = 1'b1    // drop the line if present
   } dir_op_e;

   // controller FSM
   typedef enum logic [1:0] {
      st_idle   = 2'd0,       // wait for req, latch it
      st_lookup = 2'd1,       // tag compare, victim pick, updates
      st_ack    = 2'd2        // hold response until req drops
   } dir_state_e;

endpackage

/* src/cache_dir_top.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_dir_top (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      req,
   input  cache_fmt_pkg::dir_req_t   req_in,
   output logic                      ack,
   output cache_fmt_pkg::dir_resp_t  resp
);

   // controller to both side blocks
   logic [`CACHE_NLINES_W-1:0]                  set_idx;
   logic [`CACHE_TAG_W-1:0]                     tag;
   logic                                        tag_we;
   logic [`CACHE_N_WAYS-1:0]                    tag_wr_way;
   logic                                        tag_wr_valid;
   logic                                        touch_en;
   logic [`CACHE_N_WAYS-1:0]                    touch_way;

   // side blocks back to controller
   cache_fmt_pkg::tag_look_t                    look;
   logic [`CACHE_N_WAYS-1:0][`CACHE_TAG_W-1:0]  way_tags;
   logic [`CACHE_N_WAYS-1:0]                    victim_onehot;
   logic [`CACHE_NWAY_W-1:0]                    victim_bin;

   tag_store u_tag_store (
      .clk      (clk),
      .rst_n    (rst_n),
      .set_idx  (set_idx),
      .tag      (tag),
      .we       (tag_we),
      .wr_way   (tag_wr_way),
      .wr_valid (tag_wr_valid),
      .look     (look),
      .way_tags (way_tags)
   );

   replacement_policy u_repl (
      .clk           (clk),
      .rst_n         (rst_n),
      .set_idx       (set_idx),
      .touch_en      (touch_en),
      .touch_way     (touch_way),
      .victim_onehot (victim_onehot),
      .victim_bin    (victim_bin)
   );

   dir_controller u_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .req_in        (req_in),
      .ack           (ack),
      .resp          (resp),
      .set_idx       (set_idx),
      .tag           (tag),
      .look          (look),
      .way_tags      (way_tags),
      .victim_onehot (victim_onehot),
      .victim_bin    (victim_bin),
      .tag_we        (tag_we),
      .tag_wr_way    (tag_wr_way),
      .tag_wr_valid  (tag_wr_valid),
      .touch_en      (touch_en),
      .touch_way     (touch_way)
   );

endmodule

/* src/cache_fmt_pkg.sv */
`include "cache_macros.svh"

package cache_fmt_pkg;

   // request from the outside agent, 17 bits
   typedef struct packed {
      cache_ctrl_pkg::dir_op_e   op;
      logic [`CACHE_ADDR_W-1:0]  addr;   // line address, tag over set
   } dir_req_t;

   // response, 16 bits
   typedef struct packed {
      logic                      hit;
      logic [`CACHE_NWAY_W-1:0]  way;          // binary way used
      logic                      evict_valid;  // a valid line was replaced
      logic [`CACHE_TAG_W-1:0]   evict_tag;    // tag of that line for writeback
   } dir_resp_t;

   // one way of one set in the tag store
   typedef struct packed {
      logic                      valid;
      logic [`CACHE_TAG_W-1:0]   tag;
   } dir_entry_t;

   // tag store result for the addressed set
   typedef struct packed {
      logic [`CACHE_N_WAYS-1:0]  way_hit;        // one-hot or zero
      logic [`CACHE_N_WAYS-1:0]  first_invalid;  // lowest invalid way, one-hot
      logic                      any_invalid;
   } tag_look_t;

endpackage

/* src/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// directory geometry, 4 ways by 16 sets
`define CACHE_N_WAYS   4
`define CACHE_NWAY_W   2      // binary way index
`define CACHE_N_SETS   16
`define CACHE_NLINES_W 4      // set index width

// line address split
// [15:4] tag, [3:0] set index
`define CACHE_TAG_W    12
`define CACHE_ADDR_W   16

// tree pseudo-LRU has one node per way minus one
`define CACHE_TREE_W   (`CACHE_N_WAYS - 1)

`endif

/* src/dir_controller.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module dir_controller (
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         req,
   input  cache_fmt_pkg::dir_req_t                      req_in,
   output logic                                         ack,
   output cache_fmt_pkg::dir_resp_t                     resp,
   output logic [`CACHE_NLINES_W-1:0]                   set_idx,
   output logic [`CACHE_TAG_W-1:0]                      tag,
   input  cache_fmt_pkg::tag_look_t                     look,
   input  logic [`CACHE_N_WAYS-1:0][`CACHE_TAG_W-1:0]   way_tags,
   input  logic [`CACHE_N_WAYS-1:0]                     victim_onehot,
   input  logic [`CACHE_NWAY_W-1:0]                     victim_bin,
   output logic                                         tag_we,
   output logic [`CACHE_N_WAYS-1:0]                     tag_wr_way,
   output logic                                         tag_wr_valid,
   output logic                                         touch_en,
   output logic [`CACHE_N_WAYS-1:0]                     touch_way
);

   cache_ctrl_pkg::dir_state_e state;
   cache_fmt_pkg::dir_req_t    req_q;       // latched request
   cache_fmt_pkg::dir_resp_t   resp_nxt;

   logic                       take_req;
   logic                       in_lookup;
   logic                       is_lookup_op;
   logic                       hit;
   logic                       evict;
   logic [`CACHE_N_WAYS-1:0]   alloc_way;   // one-hot way taken on a miss
   logic [`CACHE_NWAY_W-1:0]   alloc_bin;

   function automatic logic [`CACHE_NWAY_W-1:0] oh2bin(input logic [`CACHE_N_WAYS-1:0] oh);
      logic [`CACHE_NWAY_W-1:0] b;
      b = '0;
      for (int i = 0; i < `CACHE_N_WAYS; i++)
         if (oh[i]) b = b | `CACHE_NWAY_W'(i);   // OR is enough for one-hot
      return b;
   endfunction

   assign take_req     = (state == cache_ctrl_pkg::st_idle) && req && !ack;
   assign in_lookup    = (state == cache_ctrl_pkg::st_lookup);
   assign is_lookup_op = (req_q.op == cache_ctrl_pkg::op_lookup);

   // both side blocks see the same registered address
   assign set_idx = req_q.addr[`CACHE_NLINES_W-1:0];
   assign tag     = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

   assign hit   = |look.way_hit;
   assign evict = is_lookup_op && !hit && !look.any_invalid;   // full set, use the tree

   // free way first, tree victim otherwise
   assign alloc_way = look.any_invalid ? look.first_invalid : victim_onehot;
   assign alloc_bin = look.any_invalid ? oh2bin(look.first_invalid) : victim_bin;

   // updates, valid only while in st_lookup
   assign tag_we       = in_lookup && (is_lookup_op ? !hit : hit);
   assign tag_wr_way   = is_lookup_op ? alloc_way : look.way_hit;
   assign tag_wr_valid = is_lookup_op;                  // invalidate clears
   assign touch_en     = in_lookup && is_lookup_op;     // invalidate leaves the tree
   assign touch_way    = hit ? look.way_hit : alloc_way;

   always_comb begin
      resp_nxt.hit         = hit;
      resp_nxt.way         = hit ? oh2bin(look.way_hit) : (is_lookup_op ? alloc_bin : '0);
      resp_nxt.evict_valid = evict;
      resp_nxt.evict_tag   = evict ? way_tags[victim_bin] : '0;
   end

   // four-phase handshake FSM
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= cache_ctrl_pkg::st_idle;
         ack   <= 1'b0;
      end else begin
         case (state)
            cache_ctrl_pkg::st_idle:
               if (take_req) state <= cache_ctrl_pkg::st_lookup;
            cache_ctrl_pkg::st_lookup: begin
               state <= cache_ctrl_pkg::st_ack;
               ack   <= 1'b1;                            // response registered alongside
            end
            cache_ctrl_pkg::st_ack:
               if (!req) begin
                  state <= cache_ctrl_pkg::st_idle;
                  ack   <= 1'b0;
               end
            default: state <= cache_ctrl_pkg::st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take_req)  req_q <= req_in;
      if (in_lookup) resp  <= resp_nxt;                  // held through st_ack
   end

   // requester keeps req high until it sees ack, so ack only rises under req
   a_ack_under_req: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(ack) |-> req
   ) else $error("dir_controller: ack rose while req low");

endmodule

/* src/replacement_policy.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

// tree pseudo-LRU, one 3-bit tree per set
//
//               [1]             root
//         [2]         [3]       second level
//       w0   w1     w2   w3     leaves
//
// victim walk: node bit 0 goes left, 1 goes right
// touch: nodes on the path are set to point away from the touched way

module replacement_policy (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [`CACHE_NLINES_W-1:0]  set_idx,
   input  logic                        touch_en,
   input  logic [`CACHE_N_WAYS-1:0]    touch_way,       // one-hot
   output logic [`CACHE_N_WAYS-1:0]    victim_onehot,
   output logic [`CACHE_NWAY_W-1:0]    victim_bin
);

   // node 1 at bit 1, node 2 at bit 2, node 3 at bit 3
   logic [`CACHE_TREE_W:1] tree_mem [`CACHE_N_SETS];

   logic [`CACHE_TREE_W:1] tree_cur;
   logic [`CACHE_TREE_W:1] tree_nxt;
   logic                   go_right;     // root decision
   logic                   leaf_right;   // decision at the chosen child
   logic                   touch_left;   // touched way sits under node 2

   assign tree_cur = tree_mem[set_idx];   // combinational read

   // victim decode
   assign go_right      = tree_cur[1];
   assign leaf_right    = go_right ? tree_cur[3] : tree_cur[2];
   assign victim_bin    = {go_right, leaf_right};
   assign victim_onehot = `CACHE_N_WAYS'(1) << victim_bin;

   // path update for the touched way
   assign touch_left = |touch_way[1:0];

   always_comb begin
      tree_nxt    = tree_cur;
      tree_nxt[1] = touch_left;              // away from the touched half
      if (touch_left)
         tree_nxt[2] = touch_way[0];         // way 0 touched, point to way 1
      else
         tree_nxt[3] = touch_way[2];         // way 2 touched, point to way 3
   end
   // the node off the path keeps its value

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < `CACHE_N_SETS; s++)
            tree_mem[s] <= '0;               // every tree points at way 0
      end else if (touch_en) begin
         tree_mem[set_idx] <= tree_nxt;
      end
   end

   // controller must name exactly one way per touch
   a_touch_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      touch_en |-> $onehot(touch_way)
   ) else $error("replacement_policy: touch_way %b not one-hot", touch_way);

endmodule

/* src/tag_store.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_store (
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic [`CACHE_NLINES_W-1:0]                   set_idx,   // registered by the controller
   input  logic [`CACHE_TAG_W-1:0]                      tag,
   input  logic                                         we,
   input  logic [`CACHE_N_WAYS-1:0]                     wr_way,    // one-hot
   input  logic                                         wr_valid,
   output cache_fmt_pkg::tag_look_t                     look,
   output logic [`CACHE_N_WAYS-1:0][`CACHE_TAG_W-1:0]   way_tags   // all tags of the set
);

   // valid + tag per set and way
   cache_fmt_pkg::dir_entry_t dir_mem [`CACHE_N_SETS][`CACHE_N_WAYS];

   logic [`CACHE_N_WAYS-1:0] hit_vec;
   logic [`CACHE_N_WAYS-1:0] inv_vec;
   logic [`CACHE_N_WAYS-1:0] first_inv;

   // parallel compare over the addressed set
   always_comb begin
      for (int w = 0; w < `CACHE_N_WAYS; w++) begin
         hit_vec[w]  = dir_mem[set_idx][w].valid && (dir_mem[set_idx][w].tag == tag);
         inv_vec[w]  = !dir_mem[set_idx][w].valid;
         way_tags[w] = dir_mem[set_idx][w].tag;   // old tag, used for eviction
      end
   end

   // isolate lowest set bit, zero when the set is full
   assign first_inv = inv_vec & (~inv_vec + `CACHE_N_WAYS'(1));

   assign look = '{
      way_hit:       hit_vec,
      first_invalid: first_inv,
      any_invalid:   |inv_vec
   };

   // write port, lands on the edge that ends st_lookup
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < `CACHE_N_SETS; s++) begin
            for (int w = 0; w < `CACHE_N_WAYS; w++) begin
               dir_mem[s][w].valid <= 1'b0;   // tags keep whatever they held
            end
         end
      end else if (we) begin
         for (int w = 0; w < `CACHE_N_WAYS; w++) begin
            if (wr_way[w]) begin
               dir_mem[set_idx][w].valid <= wr_valid;
               if (wr_valid)
                  dir_mem[set_idx][w].tag <= tag;   // invalidate leaves the tag
            end
         end
      end
   end

   // the controller must never allocate a tag already present in the set,
   // otherwise two ways would match
   a_hit_onehot0: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(look.way_hit)
   ) else $error("tag_store: more than one way hit in set %0d", set_idx);

endmodule
